/* Bender.yml */
package:
  name: cpuCore

sources:
  # Core RTL in compile order
  - hdl/cpuPkg.sv
  - hdl/alu.sv
  - hdl/programCounter.sv
  - hdl/regFile.sv
  - hdl/busPort.sv
  - hdl/sequencer.sv
  - hdl/cpuCore.sv
  # Testbench
  - target: simulation
    files:
      - tests/memModel.sv
      - tests/tbCpuCore.sv

/* compile.f */
hdl/cpuPkg.sv
hdl/alu.sv
hdl/programCounter.sv
hdl/regFile.sv
hdl/busPort.sv
hdl/sequencer.sv
hdl/cpuCore.sv
tests/memModel.sv
tests/tbCpuCore.sv

/* hdl/alu.sv */
module alu (
    input  logic         CLK,
    input  logic         RESET,
    input  cpuPkg::dataT regA,
    input  cpuPkg::dataT regB,
    input  cpuPkg::dataT opByte,
    output cpuPkg::dataT result
);

    // Operation taken straight from the opcode high nibble
    cpuPkg::aluOpT op;
    cpuPkg::dataT  resultNext;

    assign op = cpuPkg::aluOpT'(opByte[7:4]);

    //////////////////////////////
    // Operation select
    //////////////////////////////
    always_comb begin
        case (op)
            // Arithmetic wraps modulo 256
            cpuPkg::Add:  resultNext = regA + regB;
            cpuPkg::Sub:  resultNext = regA - regB;
            // Bitwise logic
            cpuPkg::And:  resultNext = regA & regB;
            cpuPkg::Or:   resultNext = regA | regB;
            cpuPkg::Xor:  resultNext = regA ^ regB;
            // Single bit shifts of A, zero filled
            cpuPkg::ShlA: resultNext = regA << 1;
            cpuPkg::ShrA: resultNext = regA >> 1;
            cpuPkg::IncA: resultNext = regA + cpuPkg::dataT'(1);
            cpuPkg::DecA: resultNext = regA - cpuPkg::dataT'(1);
            // Unsigned compares feed the branch decision
            cpuPkg::Eq:   resultNext = (regA == regB) ? cpuPkg::branchTaken : '0;
            cpuPkg::Gt:   resultNext = (regA > regB) ? cpuPkg::branchTaken : '0;
            cpuPkg::Lt:   resultNext = (regA < regB) ? cpuPkg::branchTaken : '0;
            // Unused codes give zero
            default:      resultNext = '0;
        endcase
    end

    //////////////////////////////
    // Result register
    //////////////////////////////
    // Result for the opcode seen now is ready next cycle
    always_ff @(posedge CLK) begin
        if (RESET) begin
            result <= '0;
        end else begin
            result <= resultNext;
        end
    end

endmodule

/* hdl/busPort.sv */
module busPort (
    input  logic         CLK,
    input  logic         RESET,
    input  logic         busRdAddrValid,
    input  logic         busWrValid,
    input  cpuPkg::addrT busReqAddr,
    input  cpuPkg::dataT busWrData,
    inout  wire  cpuPkg::dataT busData,
    output cpuPkg::addrT busAddr,
    output logic         busWe,
    output cpuPkg::dataT busRdData
);

    // Byte driven onto the bus while writing
    cpuPkg::dataT wrDataQ;

    //////////////////////////////
    // Address and strobe
    //////////////////////////////
    // Address parks at the idle value unless an access is requested
    // Strobe is high for the single cycle carrying the write address
    always_ff @(posedge CLK) begin
        if (RESET) begin
            busAddr <= cpuPkg::busIdleAddr;
            busWe   <= 1'b0;
        end else begin
            busWe <= busWrValid;
            if (busRdAddrValid || busWrValid) begin
                busAddr <= busReqAddr;
            end else begin
                busAddr <= cpuPkg::busIdleAddr;
            end
        end
    end

    // Write data lines up with the strobe
    always_ff @(posedge CLK) begin
        if (busWrValid) begin
            wrDataQ <= busWrData;
        end
    end

    //////////////////////////////
    // Tristate driver
    //////////////////////////////
    // Released whenever no write is in progress
    assign busData   = busWe ? wrDataQ : 'z;
    assign busRdData = busData;

endmodule

/* hdl/cpuCore.sv */
module cpuCore (
    input  logic         CLK,
    input  logic         RESET,
    input  cpuPkg::dataT romData,
    output cpuPkg::addrT romAddress,
    inout  wire  cpuPkg::dataT busData,
    output cpuPkg::addrT busAddr,
    output logic         busWe,
    input  cpuPkg::irqT  irqRaise,
    output cpuPkg::irqT  irqAck
);

    // Sequencer to program counter
    cpuPkg::pcCmdT pcCmd;
    cpuPkg::addrT  pcLoadAddr;
    logic          useOperand;
    // Sequencer to register pair
    cpuPkg::regWrT regWr;
    cpuPkg::dataT  regWrData;
    cpuPkg::dataT  regA;
    cpuPkg::dataT  regB;
    // Sequencer to bus port
    logic          busRdAddrValid;
    logic          busWrValid;
    cpuPkg::addrT  busReqAddr;
    cpuPkg::dataT  busWrData;
    cpuPkg::dataT  busRdData;
    // Registered ALU output
    cpuPkg::dataT  aluResult;

    //////////////////////////////
    // Control
    //////////////////////////////
    sequencer i_sequencer (
        .CLK            (CLK),
        .RESET          (RESET),
        .romData        (romData),
        .aluResult      (aluResult),
        .regA           (regA),
        .regB           (regB),
        .busRdData      (busRdData),
        .irqRaise       (irqRaise),
        .irqAck         (irqAck),
        .pcCmd          (pcCmd),
        .pcLoadAddr     (pcLoadAddr),
        .useOperand     (useOperand),
        .regWr          (regWr),
        .regWrData      (regWrData),
        .busRdAddrValid (busRdAddrValid),
        .busWrValid     (busWrValid),
        .busReqAddr     (busReqAddr),
        .busWrData      (busWrData)
    );

    //////////////////////////////
    // Datapath units
    //////////////////////////////
    programCounter i_programCounter (
        .CLK        (CLK),
        .RESET      (RESET),
        .pcCmd      (pcCmd),
        .pcLoadAddr (pcLoadAddr),
        .useOperand (useOperand),
        .romAddress (romAddress)
    );

    regFile i_regFile (
        .CLK       (CLK),
        .RESET     (RESET),
        .regWr     (regWr),
        .regWrData (regWrData),
        .regA      (regA),
        .regB      (regB)
    );

    // Opcode high nibble goes straight from ROM
    alu i_alu (
        .CLK    (CLK),
        .RESET  (RESET),
        .regA   (regA),
        .regB   (regB),
        .opByte (romData),
        .result (aluResult)
    );

    busPort i_busPort (
        .CLK            (CLK),
        .RESET          (RESET),
        .busRdAddrValid (busRdAddrValid),
        .busWrValid     (busWrValid),
        .busReqAddr     (busReqAddr),
        .busWrData      (busWrData),
        .busData        (busData),
        .busAddr        (busAddr),
        .busWe          (busWe),
        .busRdData      (busRdData)
    );

endmodule

/* hdl/cpuPkg.sv */
package cpuPkg;

    //////////////////////////////
    // Widths and data types
    //////////////////////////////

    // Data path and address width
    localparam int dataWidth = 8;

    // One byte in A, B, on the bus or out of the ALU
    typedef logic [dataWidth-1:0] dataT;

    // ROM or bus address
    typedef logic [dataWidth-1:0] addrT;

    // Bit 0 is IRQ A, bit 1 is IRQ B
    typedef logic [1:0] irqT;

    //////////////////////////////
    // Opcode fields
    //////////////////////////////

    // Low nibble of the opcode byte
    typedef enum logic [3:0] {
        ReadA  = 4'h0,
        ReadB  = 4'h1,
        WriteA = 4'h2,
        WriteB = 4'h3,
        MathA  = 4'h4,
        MathB  = 4'h5,
        Branch = 4'h6,
        Goto   = 4'h7,
        GoIdle = 4'h8
    } instrT;

    // High nibble of the opcode byte
    // Also selects the compare for a branch
    typedef enum logic [3:0] {
        Add  = 4'h0,
        Sub  = 4'h1,
        And  = 4'h2,
        Or   = 4'h3,
        Xor  = 4'h4,
        ShlA = 4'h5,
        ShrA = 4'h6,
        IncA = 4'h7,
        DecA = 4'h8,
        Eq   = 4'h9,
        Gt   = 4'hA,
        Lt   = 4'hB
    } aluOpT;

    //////////////////////////////
    // Unit commands
    //////////////////////////////

    // Program counter update for the next cycle
    typedef enum logic [2:0] {
        Hold,
        Inc1,
        Inc2,
        Load,
        LoadVectorA,
        LoadVectorB
    } pcCmdT;

    // Register write select
    typedef enum logic [1:0] {
        RegNone,
        RegWriteA,
        RegWriteB
    } regWrT;

    // ROM locations holding the thread start addresses
    localparam addrT irqVectorA = 8'hFF;
    localparam addrT irqVectorB = 8'hFE;

    // Bus address parked here between accesses
    localparam addrT busIdleAddr = 8'hFF;

    // Compare result that takes a branch
    localparam dataT branchTaken = 8'h01;

endpackage

/* hdl/programCounter.sv */
module programCounter (
    input  logic          CLK,
    input  logic          RESET,
    input  cpuPkg::pcCmdT pcCmd,
    input  cpuPkg::addrT  pcLoadAddr,
    input  logic          useOperand,
    output cpuPkg::addrT  romAddress
);

    // Address of the current opcode
    cpuPkg::addrT pc;
    // Points one byte past the opcode to reach the operand
    logic         operandOffset;

    //////////////////////////////
    // Counter update
    //////////////////////////////
    always_ff @(posedge CLK) begin
        if (RESET) begin
            // Power-on start at ROM address 0
            pc            <= '0;
            operandOffset <= 1'b0;
        end else begin
            operandOffset <= useOperand;
            case (pcCmd)
                cpuPkg::Inc1:        pc <= pc + cpuPkg::addrT'(1);
                // Skip opcode and operand
                cpuPkg::Inc2:        pc <= pc + cpuPkg::addrT'(2);
                // Jump target or thread start read from ROM
                cpuPkg::Load:        pc <= pcLoadAddr;
                // Point at the vector slot, the thread start is read next
                cpuPkg::LoadVectorA: pc <= cpuPkg::irqVectorA;
                cpuPkg::LoadVectorB: pc <= cpuPkg::irqVectorB;
                default:             pc <= pc;
            endcase
        end
    end

    // ROM is combinational so this address selects this cycle's byte
    assign romAddress = pc + cpuPkg::addrT'(operandOffset);

endmodule

/* hdl/regFile.sv */
module regFile (
    input  logic          CLK,
    input  logic          RESET,
    input  cpuPkg::regWrT regWr,
    input  cpuPkg::dataT  regWrData,
    output cpuPkg::dataT  regA,
    output cpuPkg::dataT  regB
);

    //////////////////////////////
    // Data registers
    //////////////////////////////
    // Both registers start at zero
    // Only the selected one takes the write data
    always_ff @(posedge CLK) begin
        if (RESET) begin
            regA <= '0;
            regB <= '0;
        end else begin
            case (regWr)
                cpuPkg::RegWriteA: begin
                    regA <= regWrData;
                end
                cpuPkg::RegWriteB: begin
                    regB <= regWrData;
                end
                default: begin
                    // No write this cycle
                    regA <= regA;
                    regB <= regB;
                end
            endcase
        end
    end

endmodule

/* hdl/sequencer.sv */
module sequencer (
    input  logic          CLK,
    input  logic          RESET,
    input  cpuPkg::dataT  romData,
    input  cpuPkg::dataT  aluResult,
    input  cpuPkg::dataT  regA,
    input  cpuPkg::dataT  regB,
    input  cpuPkg::dataT  busRdData,
    input  cpuPkg::irqT   irqRaise,
    output cpuPkg::irqT   irqAck,
    output cpuPkg::pcCmdT pcCmd,
    output cpuPkg::addrT  pcLoadAddr,
    output logic          useOperand,
    output cpuPkg::regWrT regWr,
    output cpuPkg::dataT  regWrData,
    output logic          busRdAddrValid,
    output logic          busWrValid,
    output cpuPkg::addrT  busReqAddr,
    output cpuPkg::dataT  busWrData
);

    // One instruction in flight, each with its own chain of states
    typedef enum logic [3:0] {
        Idle,
        ThreadLoad,
        JumpWait,
        Settle,
        Decode,
        ReadAddr,
        ReadWait,
        ReadData,
        WriteAddr,
        MathSave,
        BranchEval,
        GotoLoad
    } stateT;

    stateT         state;
    stateT         stateNext;
    cpuPkg::instrT instr;
    cpuPkg::irqT   irqAckNext;
    // Target register of the current instruction, 0 for A and 1 for B
    logic          regSel;

    assign instr = cpuPkg::instrT'(romData[3:0]);

    // Operand byte serves as jump target and bus address
    assign pcLoadAddr = romData;
    assign busReqAddr = romData;
    assign busWrData  = regSel ? regB : regA;
    // Read data in the read chain, ALU result otherwise
    assign regWrData  = (state == ReadData) ? busRdData : aluResult;

    //////////////////////////////
    // State and control registers
    //////////////////////////////
    always_ff @(posedge CLK) begin
        if (RESET) begin
            // First decode at ROM address 0
            state  <= Decode;
            regSel <= 1'b0;
            irqAck <= '0;
        end else begin
            state  <= stateNext;
            irqAck <= irqAckNext;
            // Low opcode bit picks A or B for read, write and math
            if (state == Decode) begin
                regSel <= romData[0];
            end
        end
    end

    //////////////////////////////
    // Next state and commands
    //////////////////////////////
    always_comb begin
        stateNext      = state;
        pcCmd          = cpuPkg::Hold;
        useOperand     = 1'b0;
        regWr          = cpuPkg::RegNone;
        busRdAddrValid = 1'b0;
        busWrValid     = 1'b0;
        irqAckNext     = '0;

        case (state)
            // Asleep until an interrupt, IRQ A has priority
            Idle: begin
                if (irqRaise[0]) begin
                    pcCmd      = cpuPkg::LoadVectorA;
                    irqAckNext = 2'b01;
                    stateNext  = ThreadLoad;
                end else if (irqRaise[1]) begin
                    pcCmd      = cpuPkg::LoadVectorB;
                    irqAckNext = 2'b10;
                    stateNext  = ThreadLoad;
                end
            end
            // Vector slot byte is the thread start
            ThreadLoad: begin
                pcCmd     = cpuPkg::Load;
                stateNext = JumpWait;
            end
            // Extra wait after a jump
            JumpWait: stateNext = Settle;
            // Last wait before the next opcode
            Settle: stateNext = Decode;
            Decode: begin
                case (instr)
                    cpuPkg::ReadA, cpuPkg::ReadB: begin
                        useOperand = 1'b1;
                        stateNext  = ReadAddr;
                    end
                    cpuPkg::WriteA, cpuPkg::WriteB: begin
                        useOperand = 1'b1;
                        stateNext  = WriteAddr;
                    end
                    // ALU works on this opcode now
                    cpuPkg::MathA, cpuPkg::MathB: stateNext = MathSave;
                    cpuPkg::Branch: begin
                        useOperand = 1'b1;
                        stateNext  = BranchEval;
                    end
                    cpuPkg::Goto: begin
                        useOperand = 1'b1;
                        stateNext  = GotoLoad;
                    end
                    cpuPkg::GoIdle: stateNext = Idle;
                    // Undefined types hold here
                    default: stateNext = Decode;
                endcase
            end
            // Operand is the read address, put it on the bus
            ReadAddr: begin
                busRdAddrValid = 1'b1;
                stateNext      = ReadWait;
            end
            // RAM samples the address at the end of this cycle
            ReadWait: stateNext = ReadData;
            ReadData: begin
                regWr     = regSel ? cpuPkg::RegWriteB : cpuPkg::RegWriteA;
                pcCmd     = cpuPkg::Inc2;
                stateNext = Settle;
            end
            // Address, data and strobe go out together next cycle
            WriteAddr: begin
                busWrValid = 1'b1;
                pcCmd      = cpuPkg::Inc2;
                stateNext  = Settle;
            end
            MathSave: begin
                regWr     = regSel ? cpuPkg::RegWriteB : cpuPkg::RegWriteA;
                pcCmd     = cpuPkg::Inc1;
                stateNext = Settle;
            end
            // Compare result and target both ready here
            BranchEval: begin
                if (aluResult == cpuPkg::branchTaken) begin
                    pcCmd     = cpuPkg::Load;
                    stateNext = JumpWait;
                end else begin
                    pcCmd     = cpuPkg::Inc2;
                    stateNext = Settle;
                end
            end
            GotoLoad: begin
                pcCmd     = cpuPkg::Load;
                stateNext = JumpWait;
            end
            default: stateNext = Decode;
        endcase
    end

endmodule

/* tests/memModel.sv */
module memModel (
    input  logic         CLK,
    input  cpuPkg::addrT romAddress,
    output cpuPkg::dataT romData,
    input  cpuPkg::addrT busAddr,
    input  logic         busWe,
    inout  wire  cpuPkg::dataT busData
);

    // Program and data images, loaded by the testbench
    cpuPkg::dataT rom [256];
    cpuPkg::dataT ram [256];
    // Bus writes seen per address
    int           writeCount [256];

    // Read data goes out one cycle after the address
    cpuPkg::dataT rdData;
    logic         rdActive = 1'b0;

    // ROM answers in the same cycle
    assign romData = rom[romAddress];

    //////////////////////////////
    // RAM side of the bus
    //////////////////////////////
    always @(posedge CLK) begin
        // Store on the strobe edge
        if (busWe) begin
            ram[busAddr]        <= busData;
            writeCount[busAddr] <= writeCount[busAddr] + 1;
        end
        // Parked address means no read
        // Unknown address before reset also falls to the else
        if (!busWe && busAddr != cpuPkg::busIdleAddr) begin
            rdActive <= 1'b1;
        end else begin
            rdActive <= 1'b0;
        end
        rdData <= ram[busAddr];
    end

    // Bus released unless read data is due
    assign busData = rdActive ? rdData : 'z;

endmodule

/* tests/tbCpuCore.sv */
module tbCpuCore;

    localparam int clockPeriod   = 10;
    localparam int resetCycles   = 10;
    localparam int testCount     = 5;
    localparam int cyclesPerTest = 400;
    localparam int watchdogTime  = testCount * cyclesPerTest * clockPeriod
                                   + resetCycles * clockPeriod;

    logic         CLK;
    logic         RESET;
    cpuPkg::dataT romData;
    cpuPkg::addrT romAddress;
    wire  cpuPkg::dataT busData;
    cpuPkg::addrT busAddr;
    logic         busWe;
    cpuPkg::irqT  irqRaise;
    cpuPkg::irqT  irqAck;

    int           errorCount;
    int           checkCount;
    logic [31:0]  rngState;
    // Next ROM byte to load
    cpuPkg::addrT romPtr;

    cpuCore i_cpuCore (
        .CLK        (CLK),
        .RESET      (RESET),
        .romData    (romData),
        .romAddress (romAddress),
        .busData    (busData),
        .busAddr    (busAddr),
        .busWe      (busWe),
        .irqRaise   (irqRaise),
        .irqAck     (irqAck)
    );

    memModel i_memModel (
        .CLK        (CLK),
        .romAddress (romAddress),
        .romData    (romData),
        .busAddr    (busAddr),
        .busWe      (busWe),
        .busData    (busData)
    );

    //////////////////////////////
    // Clock and watchdog
    //////////////////////////////
    always #(clockPeriod / 2) CLK = ~CLK;

    initial begin
        #(watchdogTime);
        $display("ERROR: watchdog expired before the tests finished");
        $display(">>> FAIL");
        $finish;
    end

    //////////////////////////////
    // Compare tasks
    //////////////////////////////
    task automatic checkData(input string name, input cpuPkg::dataT expected,
                             input cpuPkg::dataT actual);
        checkCount++;
        if (actual !== expected) begin
            errorCount++;
            $display("MISMATCH %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic checkAddr(input string name, input cpuPkg::addrT expected,
                             input cpuPkg::addrT actual);
        checkCount++;
        if (actual !== expected) begin
            errorCount++;
            $display("MISMATCH %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic checkIrq(input string name, input cpuPkg::irqT expected,
                            input cpuPkg::irqT actual);
        checkCount++;
        if (actual !== expected) begin
            errorCount++;
            $display("MISMATCH %s: expected %b, actual %b", name, expected, actual);
        end
    endtask

    task automatic checkBit(input string name, input logic expected, input logic actual);
        checkCount++;
        if (actual !== expected) begin
            errorCount++;
            $display("MISMATCH %s: expected %b, actual %b", name, expected, actual);
        end
    endtask

    // Write count on one RAM address
    task automatic checkWriteCount(input string name, input cpuPkg::addrT addr,
                                   input int expected);
        checkCount++;
        if (i_memModel.writeCount[addr] != expected) begin
            errorCount++;
            $display("ERROR %s: %0d writes to address %h where %0d were expected",
                     name, i_memModel.writeCount[addr], addr, expected);
        end
    endtask

    //////////////////////////////
    // Reference model and helpers
    //////////////////////////////
    // Xorshift step, low byte is the operand
    function automatic cpuPkg::dataT randomByte();
        rngState = rngState ^ (rngState << 13);
        rngState = rngState ^ (rngState >> 17);
        rngState = rngState ^ (rngState << 5);
        return rngState[7:0];
    endfunction

    // ALU result by operation code
    function automatic cpuPkg::dataT expectedAlu(input logic [3:0] op,
                                                 input cpuPkg::dataT a,
                                                 input cpuPkg::dataT b);
        case (op)
            4'd0:    return a + b;
            4'd1:    return a - b;
            4'd2:    return a & b;
            4'd3:    return a | b;
            4'd4:    return a ^ b;
            4'd5:    return {a[6:0], 1'b0};
            4'd6:    return {1'b0, a[7:1]};
            4'd7:    return a + 8'd1;
            4'd8:    return a - 8'd1;
            // Unsigned compares give 1 or 0
            4'd9:    return (a == b) ? 8'h01 : 8'h00;
            4'd10:   return (a > b) ? 8'h01 : 8'h00;
            4'd11:   return (a < b) ? 8'h01 : 8'h00;
            default: return 8'h00;
        endcase
    endfunction

    // One-byte instruction
    task automatic emitOp(input cpuPkg::dataT op);
        i_memModel.rom[romPtr] = op;
        romPtr++;
    endtask

    // Opcode followed by its operand
    task automatic emitArg(input cpuPkg::dataT op, input cpuPkg::dataT arg);
        emitOp(op);
        emitOp(arg);
    endtask

    // Raise reset then wipe both memories
    task automatic holdResetAndClear();
        int i;
        @(posedge CLK);
        RESET    <= 1'b1;
        irqRaise <= '0;
        @(negedge CLK);
        for (i = 0; i < 256; i++) begin
            // Every spare ROM byte decodes as GoIdle
            i_memModel.rom[i]        = {i[7:4] ^ i[3:0], 4'h8};
            i_memModel.ram[i]        = cpuPkg::dataT'(i) ^ 8'hC3;
            i_memModel.writeCount[i] = 0;
        end
        romPtr = '0;
    endtask

    task automatic releaseReset();
        repeat (resetCycles) @(posedge CLK);
        RESET <= 1'b0;
    endtask

    // Poll until the RAM records a write at addr
    task automatic waitWrite(input string name, input cpuPkg::addrT addr);
        int cycles;
        cycles = 0;
        while (i_memModel.writeCount[addr] == 0 && cycles < cyclesPerTest) begin
            @(negedge CLK);
            cycles++;
        end
        if (i_memModel.writeCount[addr] == 0) begin
            errorCount++;
            $display("ERROR %s: no write to address %h within %0d cycles",
                     name, addr, cyclesPerTest);
        end
    endtask

    // Bus parked, no strobe, no ack, fetch at 0
    task automatic checkParkedBus(input string name);
        checkBit(name, 1'b0, busWe);
        checkData(name, 'z, busData);
        checkAddr(name, 8'hFF, busAddr);
        checkAddr(name, 8'h00, romAddress);
        checkIrq(name, 2'b00, irqAck);
    endtask

    //////////////////////////////
    // Tests
    //////////////////////////////
    task automatic testReset();
        int i;
        holdResetAndClear();
        for (i = 0; i < resetCycles; i++) begin
            @(negedge CLK);
            checkParkedBus("during reset");
        end
        @(posedge CLK);
        RESET <= 1'b0;
        // Fill program goes idle at once
        repeat (4) begin
            @(negedge CLK);
            checkParkedBus("after reset");
        end
    endtask

    task automatic testReadWrite();
        cpuPkg::dataT valueA;
        cpuPkg::dataT valueB;
        valueA = randomByte();
        valueB = randomByte();
        holdResetAndClear();
        i_memModel.ram[8'h50] = valueA;
        i_memModel.ram[8'h51] = valueB;
        emitArg(8'h00, 8'h50);
        emitArg(8'h01, 8'h51);
        emitArg(8'h03, 8'h60);
        emitArg(8'h02, 8'h61);
        emitOp(8'h08);
        releaseReset();
        waitWrite("read/write", 8'h61);
        checkData("read/write B", valueB, i_memModel.ram[8'h60]);
        checkData("read/write A", valueA, i_memModel.ram[8'h61]);
        checkWriteCount("read/write", 8'h60, 1);
        checkWriteCount("read/write", 8'h61, 1);
    endtask

    task automatic testAlu();
        int           k;
        cpuPkg::dataT opA [16];
        cpuPkg::dataT opB [16];
        holdResetAndClear();
        for (k = 0; k < 16; k++) begin
            opA[k] = randomByte();
            opB[k] = randomByte();
            i_memModel.ram[8'h10 + 2 * k] = opA[k];
            i_memModel.ram[8'h11 + 2 * k] = opB[k];
            emitArg(8'h00, cpuPkg::addrT'(8'h10 + 2 * k));
            emitArg(8'h01, cpuPkg::addrT'(8'h11 + 2 * k));
            // Even codes land in A, odd codes in B
            emitOp({k[3:0], 3'b010, k[0]});
            emitArg({7'b0000001, k[0]}, cpuPkg::addrT'(8'h40 + k));
        end
        emitOp(8'h08);
        releaseReset();
        waitWrite("alu", 8'h4F);
        for (k = 0; k < 16; k++) begin
            checkData($sformatf("alu op %0d", k), expectedAlu(k[3:0], opA[k], opB[k]),
                      i_memModel.ram[8'h40 + k]);
        end
    endtask

    // Taken path writes 5A, fall-through writes A5 after a goto skip
    task automatic runBranch(input string name, input logic [3:0] cmp,
                             input cpuPkg::dataT a, input cpuPkg::dataT b,
                             input logic taken);
        holdResetAndClear();
        i_memModel.ram[8'h10] = a;
        i_memModel.ram[8'h11] = b;
        i_memModel.ram[8'h20] = 8'h5A;
        i_memModel.ram[8'h21] = 8'hA5;
        emitArg(8'h00, 8'h10);
        emitArg(8'h01, 8'h11);
        emitArg({cmp, 4'h6}, 8'h10);
        emitArg(8'h00, 8'h21);
        emitArg(8'h07, 8'h0C);
        // Skipped by the goto
        emitArg(8'h02, 8'h31);
        emitArg(8'h02, 8'h30);
        emitArg(8'h07, 8'h14);
        // Branch target
        emitArg(8'h00, 8'h20);
        emitArg(8'h02, 8'h30);
        emitOp(8'h08);
        releaseReset();
        waitWrite(name, 8'h30);
        checkData(name, taken ? 8'h5A : 8'hA5, i_memModel.ram[8'h30]);
        // Room for a goto, a read and a write to follow
        repeat (16) @(negedge CLK);
        checkWriteCount(name, 8'h30, 1);
        checkWriteCount(name, 8'h31, 0);
    endtask

    task automatic testBranch();
        cpuPkg::dataT x;
        cpuPkg::dataT y;
        cpuPkg::dataT hi;
        cpuPkg::dataT lo;
        x = randomByte();
        y = randomByte();
        if (x == y) begin
            y = x ^ 8'h80;
        end
        hi = (x > y) ? x : y;
        lo = (x > y) ? y : x;
        runBranch("branch eq taken", 4'h9, hi, hi, 1'b1);
        runBranch("branch eq skipped", 4'h9, hi, lo, 1'b0);
        runBranch("branch gt taken", 4'hA, hi, lo, 1'b1);
        runBranch("branch gt skipped", 4'hA, lo, hi, 1'b0);
        runBranch("branch lt taken", 4'hB, lo, hi, 1'b1);
        runBranch("branch lt skipped", 4'hB, hi, lo, 1'b0);
    endtask

    // Hold the request until acked then drop it
    task automatic raiseIrq(input string name, input cpuPkg::irqT lines,
                            input cpuPkg::irqT expectedAck);
        int cycles;
        cycles = 0;
        @(posedge CLK);
        irqRaise <= lines;
        @(negedge CLK);
        while (irqAck == '0 && cycles < cyclesPerTest) begin
            @(negedge CLK);
            cycles++;
        end
        checkIrq(name, expectedAck, irqAck);
        @(posedge CLK);
        irqRaise <= '0;
        // Ack lasts one cycle only
        @(negedge CLK);
        checkIrq(name, 2'b00, irqAck);
    endtask

    task automatic testIrq();
        holdResetAndClear();
        i_memModel.ram[8'h22] = 8'hB7;
        i_memModel.ram[8'h23] = 8'hA7;
        // Main program sleeps at once
        emitOp(8'h08);
        // IRQ B thread
        romPtr = 8'h40;
        emitArg(8'h00, 8'h22);
        emitArg(8'h02, 8'h32);
        emitOp(8'h08);
        // IRQ A thread
        romPtr = 8'h60;
        emitArg(8'h00, 8'h23);
        emitArg(8'h02, 8'h33);
        emitOp(8'h08);
        i_memModel.rom[8'hFE] = 8'h40;
        i_memModel.rom[8'hFF] = 8'h60;
        releaseReset();
        raiseIrq("irq b", 2'b10, 2'b10);
        waitWrite("irq b", 8'h32);
        checkData("irq b thread", 8'hB7, i_memModel.ram[8'h32]);
        raiseIrq("irq a over b", 2'b11, 2'b01);
        waitWrite("irq a over b", 8'h33);
        checkData("irq a thread", 8'hA7, i_memModel.ram[8'h33]);
        repeat (10) @(negedge CLK);
        checkWriteCount("irq", 8'h32, 1);
        checkWriteCount("irq", 8'h33, 1);
    endtask

    //////////////////////////////
    // Test sequence
    //////////////////////////////
    initial begin
        CLK        = 1'b0;
        RESET      = 1'b1;
        irqRaise   = '0;
        errorCount = 0;
        checkCount = 0;
        rngState   = 32'ha0f2;
        romPtr     = '0;
        testReset();
        testReadWrite();
        testAlu();
        testBranch();
        testIrq();
        $display("Done: %0d checks, %0d errors", checkCount, errorCount);
        if (errorCount == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule
